//--- source/alu_pkg.sv
// ****************************************
// Shared ALU definitions
// Word and float field widths, opcode enum,
// data word type and a flag helper
// ****************************************

`default_nettype none

package alu_pkg;

	// ****************************************
	// Widths and float field positions
	// ****************************************
	localparam int WORD_W   = 32;  // Data word
	localparam int MAN_W    = 23;  // Mantissa, no hidden bit
	localparam int EXP_W    = 8;   // Two's complement exponent
	localparam int SIGN_BIT = 31;  // Float sign

	// Most negative exponent, marks a zero mantissa after normalization
	localparam logic [EXP_W-1:0] EXP_ZERO_MAN = 8'h80;

	// Opcodes, numbering kept from the processor ISA
	typedef enum logic [5:0] {
		NOP   = 6'd0,   // Pass in2
		LOD   = 6'd1,   // Pass in1
		ADD   = 6'd2,
		F_ADD = 6'd3,
		MLT   = 6'd4,
		F_MLT = 6'd5,
		DIV   = 6'd6,
		MOD   = 6'd8,
		SGN   = 6'd9,   // in2 with sign of in1
		NEG   = 6'd11,
		F_NEG = 6'd13,
		ABS   = 6'd15,
		F_ABS = 6'd17,
		PST   = 6'd19,  // Zero if negative
		I2F   = 6'd25,
		F2I   = 6'd27,
		AND   = 6'd29,
		ORR   = 6'd30,
		XOR   = 6'd31,
		INV   = 6'd32,
		LAN   = 6'd34,
		LOR   = 6'd35,
		LES   = 6'd36,
		F_LES = 6'd37,
		GRE   = 6'd38,
		F_GRE = 6'd39,
		EQU   = 6'd40,
		LIN   = 6'd41,  // Logical not
		SHL   = 6'd43,
		SHR   = 6'd44,
		SRS   = 6'd45   // Arithmetic right
	} alu_op_t;

	typedef logic signed [WORD_W-1:0] word_t;

	// Condition as a 0/1 data word
	function automatic word_t bool_word(input logic cond);
		return {{(WORD_W-1){1'b0}}, cond};
	endfunction

endpackage

`default_nettype wire

//--- source/alu_int_unit.sv
// ****************************************
// Integer unit
// Arithmetic, bitwise, compare, logical
// and shift operations, NOP and LOD
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module alu_int_unit import alu_pkg::*; (
	input  alu_op_t op,          // Operation select
	input  word_t   in1,         // Memory side operand
	input  word_t   in2,         // Accumulator side operand
	output word_t   int_result   // Zero for float or unknown codes
);

	logic  in1_neg;              // Sign of in1
	logic  in2_neg;              // Sign of in2
	logic  in1_nz;
	logic  in2_nz;
	logic  [WORD_W-1:0] shamt;   // Shift count, unsigned view of in2
	word_t in2_negated;

	assign in1_neg     = in1[WORD_W-1];
	assign in2_neg     = in2[WORD_W-1];
	assign in1_nz      = (in1 != '0);
	assign in2_nz      = (in2 != '0);
	assign shamt       = $unsigned(in2);
	assign in2_negated = -in2;

	always_comb begin
		case (op)
			// ****************************************
			// Pass-through
			// ****************************************
			NOP: int_result = in2;
			LOD: int_result = in1;

			// ****************************************
			// Arithmetic
			// ****************************************
			ADD: int_result = in1 + in2;
			MLT: int_result = in1 * in2;       // Low word of product
			DIV: int_result = in1 / in2;       // Signed, truncates toward zero
			MOD: int_result = in1 % in2;       // Sign follows in1
			SGN: begin
				// Keep in2 if signs agree, flip it otherwise
				if (in1_neg == in2_neg) begin
					int_result = in2;
				end else begin
					int_result = in2_negated;
				end
			end
			NEG: int_result = in2_negated;
			ABS: int_result = in2_neg ? in2_negated : in2;
			PST: int_result = in2_neg ? word_t'(0) : in2;  // Clamp negatives

			// Bitwise
			AND: int_result = in1 & in2;
			ORR: int_result = in1 | in2;
			XOR: int_result = in1 ^ in2;
			INV: int_result = ~in2;

			// ****************************************
			// Compare and logical, 0 or 1
			// ****************************************
			LES: int_result = bool_word(in1 < in2);   // Signed compare
			GRE: int_result = bool_word(in1 > in2);
			EQU: int_result = bool_word(in1 == in2);
			LIN: int_result = bool_word(!in2_nz);
			LAN: int_result = bool_word(in1_nz && in2_nz);
			LOR: int_result = bool_word(in1_nz || in2_nz);

			// Shifts of in1
			SHL: int_result = in1 << shamt;
			SHR: int_result = in1 >> shamt;           // Zero fill
			SRS: int_result = in1 >>> shamt;          // Sign fill

			// Float opcodes and holes in the map
			default: int_result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/alu_float_align.sv
// ****************************************
// Float aligner
// Brings two float words to one exponent
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module alu_float_align import alu_pkg::*; (
	input  word_t                    in1,
	input  word_t                    in2,
	output logic signed [EXP_W-1:0]  common_exp,  // Larger of the two
	output logic signed [MAN_W:0]    sm1,         // Signed aligned mantissas
	output logic signed [MAN_W:0]    sm2
);

	logic signed [EXP_W-1:0] e1, e2;
	logic        [MAN_W-1:0] m1, m2;
	logic signed [EXP_W:0]   diff;      // e1 - e2, one bit wider
	logic                    e2_big;    // in2 has the larger exponent
	logic        [EXP_W:0]   shift1, shift2;
	logic        [MAN_W-1:0] m1_al, m2_al;

	assign e1 = in1[SIGN_BIT-1 -: EXP_W];
	assign e2 = in2[SIGN_BIT-1 -: EXP_W];
	assign m1 = in1[MAN_W-1:0];
	assign m2 = in2[MAN_W-1:0];

	assign diff   = {e1[EXP_W-1], e1} - {e2[EXP_W-1], e2};
	assign e2_big = diff[EXP_W];

	// Only the smaller operand moves
	assign shift1 = e2_big ? -diff : '0;
	assign shift2 = e2_big ? '0 : diff;

	assign common_exp = e2_big ? e2 : e1;

	assign m1_al = m1 >> shift1;  // Large shifts just flush to zero
	assign m2_al = m2 >> shift2;

	// Apply signs
	assign sm1 = in1[SIGN_BIT] ? -{1'b0, m1_al} : {1'b0, m1_al};
	assign sm2 = in2[SIGN_BIT] ? -{1'b0, m2_al} : {1'b0, m2_al};

endmodule

`default_nettype wire

//--- source/alu_float_unit.sv
// ****************************************
// Float unit
// Add, multiply, sign ops, compares
// and int/float conversions
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module alu_float_unit import alu_pkg::*; (
	input  alu_op_t op,
	input  word_t   in1,
	input  word_t   in2,
	output word_t   float_result,  // Raw, before normalization
	output logic    float_hit,     // op is a float operation
	output logic    float_norm     // Result needs normalization
);

	// Aligned operands for add and compares
	logic signed [EXP_W-1:0]   common_exp;
	logic signed [MAN_W:0]     sm1, sm2;

	// Fields of both operands
	logic                      s1, s2;
	logic signed [EXP_W-1:0]   e1, e2;
	logic        [MAN_W-1:0]   m1, m2;

	logic signed [MAN_W+1:0]   add_sum;
	logic        [MAN_W+1:0]   add_mag;
	word_t                     add_word;

	logic        [2*MAN_W-1:0] mlt_prod;
	logic        [EXP_W:0]     mlt_exp;    // Wide exponent, catches underflow
	logic                      mlt_unf;
	word_t                     mlt_word;

	logic        [MAN_W-1:0]   i2f_mag;
	logic signed [MAN_W:0]     f2i_sm;
	word_t                     f2i_ext;
	logic        [EXP_W-1:0]   f2i_shift;
	word_t                     f2i_word;

	alu_float_align u_align (
		.in1        (in1),
		.in2        (in2),
		.common_exp (common_exp),
		.sm1        (sm1),
		.sm2        (sm2)
	);

	assign s1 = in1[SIGN_BIT];
	assign s2 = in2[SIGN_BIT];
	assign e1 = in1[SIGN_BIT-1 -: EXP_W];
	assign e2 = in2[SIGN_BIT-1 -: EXP_W];
	assign m1 = in1[MAN_W-1:0];
	assign m2 = in2[MAN_W-1:0];

	// ****************************************
	// F_ADD, one guard bit dropped
	// ****************************************
	assign add_sum  = sm1 + sm2;
	assign add_mag  = add_sum[MAN_W+1] ? -add_sum : add_sum;
	assign add_word = {add_sum[MAN_W+1], common_exp + EXP_W'(1), add_mag[MAN_W:1]};

	// F_MLT keeps upper half of product
	assign mlt_prod = m1 * m2;
	assign mlt_exp  = {e1[EXP_W-1], e1} + {e2[EXP_W-1], e2} + (EXP_W+1)'(MAN_W);
	assign mlt_unf  = (mlt_exp[EXP_W -: 2] == 2'b10);  // Wrapped below range
	assign mlt_word = {s1 ^ s2, mlt_exp[EXP_W-1:0],
		mlt_unf ? {MAN_W{1'b0}} : mlt_prod[2*MAN_W-1:MAN_W]};

	// ****************************************
	// Conversions, both on in2
	// ****************************************
	assign i2f_mag   = in2[MAN_W-1] ? -in2[MAN_W-1:0] : in2[MAN_W-1:0];

	assign f2i_sm    = s2 ? -{1'b0, m2} : {1'b0, m2};
	assign f2i_ext   = f2i_sm;                   // Sign extend to a word
	assign f2i_shift = e2[EXP_W-1] ? -e2 : e2;   // Magnitude of exponent
	assign f2i_word  = e2[EXP_W-1] ? (f2i_ext >>> f2i_shift) : (f2i_ext << f2i_shift);

	always_comb begin
		float_hit  = 1'b1;
		float_norm = 1'b0;
		case (op)
			F_ADD: begin
				float_result = add_word;
				float_norm   = 1'b1;
			end
			F_MLT: begin
				float_result = mlt_word;
				float_norm   = 1'b1;
			end
			I2F: begin
				float_result = {in2[MAN_W-1], {EXP_W{1'b0}}, i2f_mag};  // Exponent 0
				float_norm   = 1'b1;
			end
			F_NEG:   float_result = {~s2, in2[SIGN_BIT-1:0]};
			F_ABS:   float_result = {1'b0, in2[SIGN_BIT-1:0]};
			F_LES:   float_result = bool_word(sm1 < sm2);
			F_GRE:   float_result = bool_word(sm1 > sm2);
			F2I:     float_result = f2i_word;
			default: begin
				float_result = '0;
				float_hit    = 1'b0;  // Integer side owns it
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/alu_normalizer.sv
// ****************************************
// Float normalizer
// Leading zero shift with exponent fixup
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module alu_normalizer import alu_pkg::*; (
	input  word_t raw,
	output word_t normalized
);

	logic signed [EXP_W-1:0] exp_in;
	logic        [MAN_W-1:0] man_in;
	logic        [EXP_W-1:0] lz;        // Leading zero count
	logic                    man_zero;
	logic signed [EXP_W-1:0] exp_out;
	logic        [MAN_W-1:0] man_out;

	assign exp_in   = raw[SIGN_BIT-1 -: EXP_W];
	assign man_in   = raw[MAN_W-1:0];
	assign man_zero = (man_in == '0);

	// Priority count from the top bit down
	always_comb begin
		logic found;
		found = 1'b0;
		lz    = '0;
		for (int i = MAN_W-1; i >= 0; i--) begin
			if (!found) begin
				if (man_in[i]) begin
					found = 1'b1;
				end else begin
					lz = lz + EXP_W'(1);
				end
			end
		end
	end

	assign man_out = man_in << lz;                           // Top bit lands on MSB
	assign exp_out = man_zero ? EXP_ZERO_MAN : exp_in - lz;  // Zero gets minimum

	assign normalized = {raw[SIGN_BIT], exp_out, man_out};   // Sign untouched

endmodule

`default_nettype wire

//--- source/alu_result_stage.sv
// ****************************************
// Result stage
// Unit select, normalization and the
// output register with zero flag
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module alu_result_stage import alu_pkg::*; (
	input  logic  clk,
	input  logic  reset,          // Sync, active high
	input  word_t int_result,
	input  word_t float_result,
	input  logic  float_hit,      // Take the float side
	input  logic  float_norm,     // Run it through the normalizer
	output word_t out,            // Registered result
	output logic  is_zero         // Registered alongside out
);

	word_t selected;
	word_t normalized;
	word_t next_out;

	assign selected = float_hit ? float_result : int_result;

	alu_normalizer u_norm (
		.raw        (selected),
		.normalized (normalized)
	);

	assign next_out = float_norm ? normalized : selected;

	// ****************************************
	// Output register, one cycle latency
	// ****************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			out     <= '0;
			is_zero <= 1'b1;     // Matches cleared out
		end else begin
			out     <= next_out;
			is_zero <= (next_out == '0);
		end
	end

endmodule

`default_nettype wire

//--- source/alu_fx.sv
// ****************************************
// ALU top level
// Integer and float units feeding the
// registered result stage
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module alu_fx import alu_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  alu_op_t op,
	input  word_t   in1,
	input  word_t   in2,
	output word_t   out,
	output logic    is_zero
);

	word_t int_result;
	word_t float_result;
	logic  float_hit;
	logic  float_norm;

	// Both units decode op in parallel
	alu_int_unit u_int (
		.op         (op),
		.in1        (in1),
		.in2        (in2),
		.int_result (int_result)
	);

	alu_float_unit u_float (
		.op           (op),
		.in1          (in1),
		.in2          (in2),
		.float_result (float_result),
		.float_hit    (float_hit),
		.float_norm   (float_norm)
	);

	alu_result_stage u_result (
		.clk          (clk),
		.reset        (reset),
		.int_result   (int_result),
		.float_result (float_result),
		.float_hit    (float_hit),
		.float_norm   (float_norm),
		.out          (out),
		.is_zero      (is_zero)
	);

endmodule

`default_nettype wire

//--- testbench/alu_fx_asserts.sv
// ****************************************
// Result stage assertions
// Zero flag, select flags, reset value
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module alu_fx_asserts import alu_pkg::*; (
	input logic  clk,
	input logic  reset,
	input logic  float_hit,
	input logic  float_norm,
	input word_t out,
	input logic  is_zero
);

	int fail_count = 0;  // Failures seen so far

	// Flag always tracks the registered word
	a_zero_flag: assert property (@(posedge clk) disable iff (reset)
		is_zero == (out == '0))
		else begin
			fail_count = fail_count + 1;
			$error("is_zero does not match out");
		end

	// Normalize only float results
	a_norm_hit: assert property (@(posedge clk) disable iff (reset)
		float_norm |-> float_hit)
		else begin
			fail_count = fail_count + 1;
			$error("float_norm without float_hit");
		end

	a_reset_clears: assert property (@(posedge clk) reset |=> (out == '0 && is_zero))
		else begin
			fail_count = fail_count + 1;
			$error("out not cleared after reset");
		end

endmodule

bind alu_result_stage alu_fx_asserts u_asserts (
	.clk        (clk),
	.reset      (reset),
	.float_hit  (float_hit),
	.float_norm (float_norm),
	.out        (out),
	.is_zero    (is_zero)
);

`default_nettype wire

//--- testbench/alu_fx_tb.sv
// ****************************************
// ALU testbench
// Directed table, random integer rows,
// pipelined checks and watchdog
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module alu_fx_tb import alu_pkg::*;;

	localparam int CLK_PERIOD = 40;
	localparam int N_RAND     = 40;   // Random integer rows

	logic    clk;
	logic    reset;
	alu_op_t op;
	word_t   in1, in2;
	word_t   out;
	logic    is_zero;

	logic [5:0]  op_q[$];             // Stimulus and expected columns
	logic [31:0] a_q[$], b_q[$], exp_q[$];
	bit          rows_ready = 1'b0;
	integer      seed;

	alu_fx uut (
		.clk     (clk),
		.reset   (reset),
		.op      (op),
		.in1     (in1),
		.in2     (in2),
		.out     (out),
		.is_zero (is_zero)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("[ERROR] %0d ns: %s got %h expected %h", $time, what, got, want);
			abort_run();
		end
	endtask

	task automatic add_row(input logic [5:0] code, input logic [31:0] a, b, res);
		op_q.push_back(code);
		a_q.push_back(a);
		b_q.push_back(b);
		exp_q.push_back(res);
	endtask

	// Reference results for the random rows
	function automatic logic [31:0] random_expect(input logic [5:0] code, input logic [31:0] a, b);
		case (code)
			ADD:     return a + b;
			XOR:     return a ^ b;
			SHR:     return a >> b[4:0];  // Zero fill
			default: return (a == b) ? 32'd1 : 32'd0;
		endcase
	endfunction

	initial begin
		logic [31:0] a, b;
		logic [5:0]  code;
		int          n_rows;
		clk   = 1'b0;
		reset = 1'b1;
		op    = NOP;
		in1   = '0;
		in2   = '0;
		seed  = 32'h6644;

		// ****************************************
		// Directed rows with expected out
		// ****************************************
		add_row(NOP, 32'h11111111, 32'h22222222, 32'h22222222);
		add_row(LOD, 32'h11111111, 32'h22222222, 32'h11111111);
		add_row(ADD, 32'd5,        32'd7,        32'd12);
		add_row(ADD, 32'hFFFFFFFF, 32'd1,        32'd0);         // Wraps to zero
		add_row(MLT, 32'd6,        32'hFFFFFFFD, 32'hFFFFFFEE);  // 6 * -3
		add_row(DIV, 32'd100,      32'd7,        32'd14);
		add_row(MOD, 32'hFFFFFF9C, 32'd7,        32'hFFFFFFFE);  // -100 % 7
		add_row(SGN, 32'hFFFFFFFF, 32'd5,        32'hFFFFFFFB);
		add_row(SGN, 32'hFFFFFFFE, 32'hFFFFFFFB, 32'hFFFFFFFB);  // Both negative
		add_row(NEG, 32'd0,        32'd9,        32'hFFFFFFF7);
		add_row(ABS, 32'd0,        32'hFFFFFFF7, 32'd9);
		add_row(PST, 32'd0,        32'hFFFFFFF7, 32'd0);
		add_row(PST, 32'd0,        32'd9,        32'd9);
		add_row(AND, 32'hF0F0F0F0, 32'hFF00FF00, 32'hF000F000);
		add_row(ORR, 32'hF0F0F0F0, 32'hFF00FF00, 32'hFFF0FFF0);
		add_row(XOR, 32'hF0F0F0F0, 32'hFF00FF00, 32'h0FF00FF0);
		add_row(INV, 32'd0,        32'h0F0F0F0F, 32'hF0F0F0F0);
		add_row(LES, 32'hFFFFFFFF, 32'd1,        32'd1);         // Signed
		add_row(GRE, 32'hFFFFFFFF, 32'd1,        32'd0);
		add_row(EQU, 32'd7,        32'd7,        32'd1);
		add_row(LIN, 32'd3,        32'd0,        32'd1);
		add_row(LAN, 32'd3,        32'd0,        32'd0);
		add_row(LOR, 32'd0,        32'd4,        32'd1);
		add_row(SHL, 32'd1,        32'd4,        32'h00000010);
		add_row(SHR, 32'h80000000, 32'd4,        32'h08000000);
		add_row(SRS, 32'h80000000, 32'd4,        32'hF8000000);

		// Float rows with F_ADD, F_MLT and I2F normalized
		add_row(I2F,   32'd0,        32'd1,        32'h75400000);  // 0x400000 at exp -22
		add_row(I2F,   32'd0,        32'h007FFFFF, 32'hF5400000);  // -1
		add_row(F_ADD, 32'h00400000, 32'h00400000, 32'h00C00000);
		add_row(F_ADD, 32'h00C00000, 32'h00400000, 32'h00E00000);  // Exponents differ
		add_row(F_ADD, 32'h00400000, 32'h80400000, 32'h40000000);  // Cancels to exp 0x80
		add_row(F_ADD, 32'h00400000, 32'h80C00000, 32'h80400000);
		add_row(F_MLT, 32'h00400000, 32'h00400000, 32'h0B400000);
		add_row(F_MLT, 32'hFFE00000, 32'h01400000, 32'h8BE00000);
		add_row(F_MLT, 32'h40400000, 32'h40400000, 32'h40000000);  // Underflow
		add_row(F_NEG, 32'd0,        32'h00C00000, 32'h80C00000);
		add_row(F_ABS, 32'd0,        32'h80C00000, 32'h00C00000);
		add_row(F_LES, 32'h80400000, 32'h00400000, 32'd1);
		add_row(F_GRE, 32'h00C00000, 32'h00600000, 32'd1);
		add_row(F2I,   32'd0,        32'h01800005, 32'h00000028);  // 5 << 3
		add_row(F2I,   32'd0,        32'hFF000010, 32'hFFFFFFFC);  // -16 >>> 2
		add_row(6'd7,  32'd5,        32'd5,        32'd0);         // Undefined codes
		add_row(6'd63, 32'd5,        32'd5,        32'd0);

		// ****************************************
		// Random integer rows
		// ****************************************
		for (int i = 0; i < N_RAND; i++) begin
			a = $random(seed);
			b = $random(seed);
			case (i % 4)
				0: code = ADD;
				1: code = XOR;
				2: begin
					code = SHR;
					b    = b & 32'd31;
				end
				default: begin
					code = EQU;
					if (i % 8 == 3) begin
						b = a;  // Force some hits
					end
				end
			endcase
			add_row(code, a, b, random_expect(code, a, b));
		end
		rows_ready = 1'b1;
		n_rows     = op_q.size();

		// Cleared state checked before reset drops at edge 10
		repeat (9) @(posedge clk);
		@(negedge clk);
		check_value("out after reset", out, 32'd0);
		check_value("is_zero after reset", {31'b0, is_zero}, 32'd1);
		@(posedge clk);
		reset <= 1'b0;

		// New row every edge with its result one edge later
		for (int i = 0; i <= n_rows; i++) begin
			@(posedge clk);
			if (i < n_rows) begin
				op  <= alu_op_t'(op_q[i]);
				in1 <= a_q[i];
				in2 <= b_q[i];
			end
			@(negedge clk);
			if (i > 0) begin
				check_value($sformatf("row %0d out", i - 1), out, exp_q[i-1]);
				check_value($sformatf("row %0d is_zero", i - 1), {31'b0, is_zero},
					{31'b0, exp_q[i-1] == 32'd0});
			end
		end

		$display("Everything OK");
		$finish;
	end

	// Stop on the first bound assertion failure
	initial begin
		wait (uut.u_result.u_asserts.fail_count != 0);
		$display("A bound assertion on the result stage failed");
		abort_run();
	end

	// Watchdog sized from all rows plus reset and slack
	initial begin
		int limit_ns;
		wait (rows_ready);
		limit_ns = (op_q.size() + 20) * CLK_PERIOD;
		#(limit_ns);
		$display("Timeout: the run did not finish within %0d ns", limit_ns);
		abort_run();
	end

endmodule

`default_nettype wire

//--- alu_fx.f
source/alu_pkg.sv
source/alu_int_unit.sv
source/alu_float_align.sv
source/alu_float_unit.sv
source/alu_normalizer.sv
source/alu_result_stage.sv
source/alu_fx.sv
testbench/alu_fx_asserts.sv
testbench/alu_fx_tb.sv
